//--- hw/cpuPkg.sv
package cpuPkg;

    localparam int DataWidth    = 32;  // Machine word
    localparam int RegAddrWidth = 5;   // Register index
    localparam int ImemBytes    = 1024;
    localparam int DmemBytes    = 1024;
    localparam int MaxSteps     = 256; // Step budget per run
    localparam int StepWidth    = 9;   // Holds 0..MaxSteps

    localparam logic [5:0] OpRType = 6'b000000;
    localparam logic [5:0] OpAddi  = 6'b001000;
    localparam logic [5:0] OpLw    = 6'b100011;
    localparam logic [5:0] OpSw    = 6'b101011;
    localparam logic [5:0] OpBeq   = 6'b000100;
    localparam logic [5:0] OpBne   = 6'b000101;
    localparam logic [5:0] OpJ     = 6'b000010;
    localparam logic [5:0] OpHalt  = 6'b111111; // Ends a run

    localparam logic [5:0] FnAdd = 6'b100000;
    localparam logic [5:0] FnSub = 6'b100010;
    localparam logic [5:0] FnAnd = 6'b100100;
    localparam logic [5:0] FnOr  = 6'b100101;
    localparam logic [5:0] FnSlt = 6'b101010;

    typedef enum logic [2:0] {
        AluAnd = 3'b000,
        AluOr  = 3'b001,
        AluAdd = 3'b010,
        AluSub = 3'b110,  // Bit 2 inverts operand B
        AluSlt = 3'b111
    } aluOp_e;

    typedef logic [DataWidth-1:0]    word_t;
    typedef logic [RegAddrWidth-1:0] regAddr_t;

    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            regAddr_t   rs;
            regAddr_t   rt;
            regAddr_t   rd;
            logic [4:0] shamt;  // Unused by this subset
            logic [5:0] funct;
        } rFields;
        struct packed {
            logic [5:0]  opcode;
            regAddr_t    rs;
            regAddr_t    rt;
            logic [15:0] imm;
        } iFields;
    } instr_u;

    typedef enum logic [1:0] {Idle, Run, Done} runState_e;

endpackage

//--- hw/cpuCtrlIf.sv
`timescale 1ns/1ns
interface cpuCtrlIf;

    logic           regDst;    // 1 selects rd
    logic           aluSrc;    // 1 selects immediate
    logic           memWrite;
    logic           memToReg;
    logic           regWrite;
    logic           beq;
    logic           bne;
    logic           jump;
    cpuPkg::aluOp_e aluOp;
    logic           halt;      // HALT opcode in fetch slot
    logic           active;    // Current instruction may commit

    modport decoder (output regDst, aluSrc, memWrite, memToReg, regWrite,
                      beq, bne, jump, aluOp, halt);
    modport seq     (input halt, output active);
    modport fetch   (input beq, bne, jump, halt, active);
    modport exec    (input aluSrc, aluOp, regDst, regWrite, memToReg, memWrite,
                      active);

endinterface

//--- hw/runControl.sv
`timescale 1ns/1ns
module runControl (
    input  logic     Clk,
    input  logic     reset,
    input  logic     runReq,
    output logic     runAck,
    input  logic     budgetHit,
    cpuCtrlIf.seq    ctrl
);

    cpuPkg::runState_e state;

    always_ff @(posedge Clk) begin
        if (reset) begin
            state <= cpuPkg::Idle;
        end else begin
            case (state)
                cpuPkg::Idle: begin
                    if (runReq && !runAck) begin  // New request, previous ack gone
                        state <= cpuPkg::Run;
                    end
                end
                cpuPkg::Run: begin
                    if (ctrl.halt || budgetHit) begin // HALT fetched or budget spent
                        state <= cpuPkg::Done;
                    end
                end
                cpuPkg::Done: begin
                    if (!runReq) begin  // Requester released
                        state <= cpuPkg::Idle;
                    end
                end
                default: state <= cpuPkg::Idle;
            endcase
        end
    end

    assign runAck = (state == cpuPkg::Done); // High from cycle after the last step

    // The ending instruction itself must not commit
    assign ctrl.active = (state == cpuPkg::Run) && !ctrl.halt && !budgetHit;

endmodule

//--- hw/stepCounter.sv
`timescale 1ns/1ns
module stepCounter (
    input  logic                         Clk,
    input  logic                         reset,
    input  logic                         clear,     // Run request level
    input  logic                         step,      // Instruction commits this cycle
    output logic [cpuPkg::StepWidth-1:0] retired,
    output logic                         budgetHit,
    output logic                         overrun
);

    logic clearQ;      // Previous clear level
    logic clearPulse;  // Rising edge marks run start

    assign clearPulse = clear && !clearQ;
    assign budgetHit  = (retired == cpuPkg::StepWidth'(cpuPkg::MaxSteps));

    always_ff @(posedge Clk) begin
        if (reset) begin
            clearQ  <= 1'b0;
            retired <= '0;
            overrun <= 1'b0;
        end else begin
            clearQ <= clear;
            if (clearPulse) begin
                retired <= '0;
                overrun <= 1'b0;
            end else begin
                if (step) begin
                    retired <= retired + cpuPkg::StepWidth'(1);
                end
                if (budgetHit) begin
                    overrun <= 1'b1;  // Sticky until next run
                end
            end
        end
    end

endmodule

//--- hw/instrDecoder.sv
`timescale 1ns/1ns
module instrDecoder (
    input  cpuPkg::instr_u instr,
    cpuCtrlIf.decoder      ctrl
);

    always_comb begin
        ctrl.regDst   = 1'b0;  // Safe defaults, no side effects
        ctrl.aluSrc   = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.beq      = 1'b0;
        ctrl.bne      = 1'b0;
        ctrl.jump     = 1'b0;
        ctrl.halt     = 1'b0;
        ctrl.aluOp    = cpuPkg::AluAnd;

        case (instr.rFields.opcode)
            cpuPkg::OpRType: begin
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                case (instr.rFields.funct)
                    cpuPkg::FnAdd: ctrl.aluOp = cpuPkg::AluAdd;
                    cpuPkg::FnSub: ctrl.aluOp = cpuPkg::AluSub;
                    cpuPkg::FnAnd: ctrl.aluOp = cpuPkg::AluAnd;
                    cpuPkg::FnOr:  ctrl.aluOp = cpuPkg::AluOr;
                    cpuPkg::FnSlt: ctrl.aluOp = cpuPkg::AluSlt;
                    default:       ctrl.regWrite = 1'b0; // Unknown funct, no write
                endcase
            end
            cpuPkg::OpAddi: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = cpuPkg::AluAdd;
            end
            cpuPkg::OpLw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = cpuPkg::AluAdd;  // Base plus offset
            end
            cpuPkg::OpSw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluOp    = cpuPkg::AluAdd;
            end
            cpuPkg::OpBeq: begin
                ctrl.beq   = 1'b1;
                ctrl.aluOp = cpuPkg::AluSub;     // Compare via zero
            end
            cpuPkg::OpBne: begin
                ctrl.bne   = 1'b1;
                ctrl.aluOp = cpuPkg::AluSub;
            end
            cpuPkg::OpJ:    ctrl.jump = 1'b1;
            cpuPkg::OpHalt: ctrl.halt = 1'b1;
            default: begin
                ctrl.halt = 1'b0;  // Unknown opcode acts as a no-op
            end
        endcase
    end

endmodule

//--- hw/fetchUnit.sv
`timescale 1ns/1ns
module fetchUnit (
    input  logic           Clk,
    input  logic           reset,
    input  logic           loadEn,
    input  cpuPkg::word_t  loadAddr,
    input  cpuPkg::word_t  loadData,
    input  logic           restart,  // Run requested
    input  logic           zero,
    output cpuPkg::instr_u instr,
    output cpuPkg::word_t  pcPlus4,
    cpuCtrlIf.fetch        ctrl
);

    logic [7:0] imem [cpuPkg::ImemBytes];  // Byte-addressed program store

    cpuPkg::word_t pc;
    cpuPkg::word_t immExt;
    cpuPkg::word_t branchTarget;
    cpuPkg::word_t jumpTarget;
    cpuPkg::word_t nextPc;
    logic          branchTaken;
    logic [$clog2(cpuPkg::ImemBytes)-3:0] fetchWord;  // Word index of PC
    logic [$clog2(cpuPkg::ImemBytes)-3:0] loadWord;

    assign fetchWord = pc[$clog2(cpuPkg::ImemBytes)-1:2];
    assign loadWord  = loadAddr[$clog2(cpuPkg::ImemBytes)-1:2];

    // Big-endian word fetch
    assign instr = {imem[{fetchWord, 2'd0}], imem[{fetchWord, 2'd1}],
                    imem[{fetchWord, 2'd2}], imem[{fetchWord, 2'd3}]};

    assign pcPlus4      = pc + 32'd4;
    assign immExt       = {{16{instr.iFields.imm[15]}}, instr.iFields.imm};
    assign branchTarget = pcPlus4 + {immExt[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], instr.iFields.rs, instr.iFields.rt,
                           instr.iFields.imm, 2'b00};  // 26-bit field, word aligned
    assign branchTaken  = (ctrl.beq && zero) || (ctrl.bne && !zero);

    always_comb begin
        if (ctrl.halt) begin
            nextPc = pc;            // Park on HALT
        end else if (ctrl.jump) begin
            nextPc = jumpTarget;
        end else if (branchTaken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            pc <= '0;
        end else if (restart && !ctrl.active) begin
            pc <= '0;               // Run entry and after the last step
        end else if (ctrl.active) begin
            pc <= nextPc;
        end
    end

    always_ff @(posedge Clk) begin
        if (loadEn && !restart && !ctrl.active) begin  // Idle only
            imem[{loadWord, 2'd0}] <= loadData[31:24];
            imem[{loadWord, 2'd1}] <= loadData[23:16];
            imem[{loadWord, 2'd2}] <= loadData[15:8];
            imem[{loadWord, 2'd3}] <= loadData[7:0];
        end
    end

endmodule

//--- hw/regFile.sv
`timescale 1ns/1ns
module regFile (
    input  logic           Clk,
    input  cpuPkg::instr_u instr,
    input  cpuPkg::word_t  aluResult,
    input  cpuPkg::word_t  memData,
    output cpuPkg::word_t  readA,
    output cpuPkg::word_t  readB,
    cpuCtrlIf.exec         ctrl
);

    cpuPkg::word_t    regs [2**cpuPkg::RegAddrWidth];
    cpuPkg::regAddr_t wAddr;
    cpuPkg::word_t    wData;

    assign wAddr = ctrl.regDst ? instr.rFields.rd : instr.rFields.rt;  // R-type vs I-type
    assign wData = ctrl.memToReg ? memData : aluResult;

    assign readA = (instr.rFields.rs == '0) ? '0 : regs[instr.rFields.rs];  // r0 is zero
    assign readB = (instr.rFields.rt == '0) ? '0 : regs[instr.rFields.rt];

    always_ff @(posedge Clk) begin
        if (ctrl.active && ctrl.regWrite && (wAddr != '0)) begin
            regs[wAddr] <= wData;
        end
    end

endmodule

//--- hw/executeUnit.sv
`timescale 1ns/1ns
module executeUnit (
    input  cpuPkg::instr_u instr,
    input  cpuPkg::word_t  readA,
    input  cpuPkg::word_t  readB,
    output cpuPkg::word_t  aluResult,
    output logic           zero,
    cpuCtrlIf.exec         ctrl
);

    cpuPkg::word_t immExt;
    cpuPkg::word_t opB;

    assign immExt = {{16{instr.iFields.imm[15]}}, instr.iFields.imm};
    assign opB    = ctrl.aluSrc ? immExt : readB;  // Immediate or rt

    always_comb begin
        case (ctrl.aluOp)
            cpuPkg::AluAnd: aluResult = readA & opB;
            cpuPkg::AluOr:  aluResult = readA | opB;
            cpuPkg::AluAdd: aluResult = readA + opB;
            cpuPkg::AluSub: aluResult = readA - opB;
            cpuPkg::AluSlt: begin
                // Signed compare
                aluResult = ($signed(readA) < $signed(opB)) ? 32'd1 : 32'd0;
            end
            default:        aluResult = '0;
        endcase
    end

    assign zero = (aluResult == '0);  // Branch compare

endmodule

//--- hw/dataMem.sv
`timescale 1ns/1ns
module dataMem (
    input  logic          Clk,
    input  cpuPkg::word_t addr,
    input  cpuPkg::word_t writeData,
    output cpuPkg::word_t readData,
    input  cpuPkg::word_t peekAddr,
    output cpuPkg::word_t peekData,
    cpuCtrlIf.exec        ctrl
);

    logic [7:0] dmem [cpuPkg::DmemBytes];
    logic [$clog2(cpuPkg::DmemBytes)-3:0] accWord;   // Word index, aligned only
    logic [$clog2(cpuPkg::DmemBytes)-3:0] peekWord;

    assign accWord  = addr[$clog2(cpuPkg::DmemBytes)-1:2];
    assign peekWord = peekAddr[$clog2(cpuPkg::DmemBytes)-1:2];

    assign readData = {dmem[{accWord, 2'd0}], dmem[{accWord, 2'd1}],
                       dmem[{accWord, 2'd2}], dmem[{accWord, 2'd3}]};
    assign peekData = {dmem[{peekWord, 2'd0}], dmem[{peekWord, 2'd1}],
                       dmem[{peekWord, 2'd2}], dmem[{peekWord, 2'd3}]};  // Same-cycle peek

    always_ff @(posedge Clk) begin
        if (ctrl.memWrite && ctrl.active) begin
            dmem[{accWord, 2'd0}] <= writeData[31:24];  // MSB first
            dmem[{accWord, 2'd1}] <= writeData[23:16];
            dmem[{accWord, 2'd2}] <= writeData[15:8];
            dmem[{accWord, 2'd3}] <= writeData[7:0];
        end
    end

endmodule

//--- hw/cpuTop.sv
`timescale 1ns/1ns
module cpuTop (
    input  logic                         Clk,
    input  logic                         reset,
    input  logic                         runReq,
    output logic                         runAck,
    input  logic                         loadEn,
    input  cpuPkg::word_t                loadAddr,
    input  cpuPkg::word_t                loadData,
    input  cpuPkg::word_t                peekAddr,
    output cpuPkg::word_t                peekData,
    output logic [cpuPkg::StepWidth-1:0] retired,
    output logic                         overrun
);

    cpuPkg::instr_u instr;
    cpuPkg::word_t  readA;
    cpuPkg::word_t  readB;
    cpuPkg::word_t  aluResult;
    cpuPkg::word_t  memData;
    logic           zero;
    logic           budgetHit;

    cpuCtrlIf ctrl ();  // Decoded control plus run gating

    runControl runCtrl0 (
        .Clk       (Clk),
        .reset     (reset),
        .runReq    (runReq),
        .runAck    (runAck),
        .budgetHit (budgetHit),
        .ctrl      (ctrl)
    );

    stepCounter steps0 (
        .Clk       (Clk),
        .reset     (reset),
        .clear     (runReq),       // Edge taken inside
        .step      (ctrl.active),  // One commit per active cycle
        .retired   (retired),
        .budgetHit (budgetHit),
        .overrun   (overrun)
    );

    instrDecoder decode0 (
        .instr (instr),
        .ctrl  (ctrl)
    );

    fetchUnit fetch0 (
        .Clk      (Clk),
        .reset    (reset),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .restart  (runReq),
        .zero     (zero),
        .instr    (instr),
        .pcPlus4  (),
        .ctrl     (ctrl)
    );

    regFile regs0 (
        .Clk       (Clk),
        .instr     (instr),
        .aluResult (aluResult),
        .memData   (memData),
        .readA     (readA),
        .readB     (readB),
        .ctrl      (ctrl)
    );

    executeUnit exec0 (
        .instr     (instr),
        .readA     (readA),
        .readB     (readB),
        .aluResult (aluResult),
        .zero      (zero),
        .ctrl      (ctrl)
    );

    dataMem dmem0 (
        .Clk       (Clk),
        .addr      (aluResult),  // Effective address
        .writeData (readB),      // sw stores rt
        .readData  (memData),
        .peekAddr  (peekAddr),
        .peekData  (peekData),
        .ctrl      (ctrl)
    );

endmodule

//--- verif/cpuTb_asserts.sv
`timescale 1ns/1ns
module cpuTbAsserts (
    input logic              Clk,
    input logic              reset,
    input logic              runReq,
    input logic              runAck,
    input cpuPkg::runState_e state
);

    int assertFails = 0;  // Failed assertion count

    ackAfterReq: assert property (@(posedge Clk) disable iff (reset)
        $rose(runAck) |-> $past(runReq))
        else begin
            assertFails++;
            $error("runAck rose without a pending runReq");
        end

    noAckFromIdle: assert property (@(posedge Clk) disable iff (reset)
        (state == cpuPkg::Idle) |=> !runAck)
        else begin
            assertFails++;
            $error("runAck rose straight out of Idle");
        end

    ackHeldWithReq: assert property (@(posedge Clk) disable iff (reset)
        (runAck && runReq) |=> runAck)
        else begin
            assertFails++;
            $error("runAck dropped while runReq still high");
        end

endmodule

//--- verif/cpuTb.sv
`timescale 1ns/1ns
module cpuTb;

    logic                         Clk;
    logic                         reset;
    logic                         runReq;
    logic                         runAck;
    logic                         loadEn;
    cpuPkg::word_t                loadAddr;
    cpuPkg::word_t                loadData;
    cpuPkg::word_t                peekAddr;
    cpuPkg::word_t                peekData;
    logic [cpuPkg::StepWidth-1:0] retired;
    logic                         overrun;

    cpuPkg::word_t prog [$];  // Program image in words
    int            checks = 0;
    int            errors = 0;

    cpuTop dut0 (
        .Clk      (Clk),
        .reset    (reset),
        .runReq   (runReq),
        .runAck   (runAck),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .peekAddr (peekAddr),
        .peekData (peekData),
        .retired  (retired),
        .overrun  (overrun)
    );

    bind runControl cpuTbAsserts asserts0 (
        .Clk    (Clk),
        .reset  (reset),
        .runReq (runReq),
        .runAck (runAck),
        .state  (state)
    );

    initial Clk = 1'b0;
    always #50 Clk = ~Clk;  // 100 ns period

    function automatic cpuPkg::word_t rTypeWord(input cpuPkg::regAddr_t rd,
                                                input cpuPkg::regAddr_t rs,
                                                input cpuPkg::regAddr_t rt,
                                                input logic [5:0] funct);
        return {cpuPkg::OpRType, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic cpuPkg::word_t immWord(input logic [5:0] op,
                                              input cpuPkg::regAddr_t rt,
                                              input cpuPkg::regAddr_t rs,
                                              input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic cpuPkg::word_t jumpWord(input logic [25:0] target);
        return {cpuPkg::OpJ, target};  // Word index target
    endfunction

    function automatic cpuPkg::word_t signedLess(input cpuPkg::word_t x,
                                                 input cpuPkg::word_t y);
        if (x[31] != y[31]) begin
            return {31'd0, x[31]};  // Only the negative one is smaller
        end
        return {31'd0, (x < y)};    // Same sign orders like unsigned
    endfunction

    task automatic finishRun();
        int asserts;
        asserts = dut0.runCtrl0.asserts0.assertFails;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, asserts);
        if (errors == 0 && asserts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    task automatic checkWord(input string name, input cpuPkg::word_t want,
                             input cpuPkg::word_t got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[ERROR] %0t ns %s: expected %h, got %h", $time, name, want, got);
        end
    endtask

    task automatic checkCount(input string name, input logic [cpuPkg::StepWidth-1:0] want,
                              input logic [cpuPkg::StepWidth-1:0] got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[ERROR] %0t ns %s: expected %0d, got %0d", $time, name, want, got);
        end
    endtask

    task automatic checkFlag(input string name, input logic want, input logic got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[ERROR] %0t ns %s: expected %b, got %b", $time, name, want, got);
        end
    endtask

    task automatic loadProgram();
        int i;
        for (i = 0; i < prog.size(); i++) begin
            @(posedge Clk);
            loadEn   <= 1'b1;
            loadAddr <= cpuPkg::word_t'(4 * i);  // Byte address of word
            loadData <= prog[i];
        end
        @(posedge Clk);
        loadEn <= 1'b0;
    endtask

    task automatic waitForAck(input logic level, input string what);
        int cnt;
        cnt = 0;
        while (runAck !== level && cnt < 4 * cpuPkg::MaxSteps) begin
            @(negedge Clk);  // Sample mid-cycle
            cnt++;
        end
        if (runAck !== level) begin
            $display("Timeout: runAck did not %s", what);
            errors++;
        end
    endtask

    task automatic runProgram(input int holdCycles);
        int i;
        waitForAck(1'b0, "drop before the request");
        @(posedge Clk);
        runReq <= 1'b1;
        @(negedge Clk);
        waitForAck(1'b1, "rise at the end of the run");
        for (i = 0; i < holdCycles; i++) begin
            @(negedge Clk);
            checkFlag("runAck held", 1'b1, runAck);  // Back-pressure
        end
        @(posedge Clk);
        runReq <= 1'b0;
        @(negedge Clk);
        waitForAck(1'b0, "drop after the release");
    endtask

    task automatic peekWord(input cpuPkg::word_t addr, output cpuPkg::word_t data);
        @(posedge Clk);
        peekAddr <= addr;
        @(negedge Clk);
        data = peekData;  // Combinational read
    endtask

    task automatic aluTest();
        cpuPkg::word_t a;
        cpuPkg::word_t b;
        cpuPkg::word_t got;
        cpuPkg::word_t want [6];
        int            i;
        a = 32'd100;
        b = 32'hFFFF_FFFD;  // -3
        want[0] = a + b;
        want[1] = a - b;
        want[2] = a & b;
        want[3] = a | b;
        want[4] = signedLess(a, b);
        want[5] = signedLess(b, a);
        prog.delete();
        prog.push_back(immWord(cpuPkg::OpAddi, 5'd1, 5'd0, a[15:0]));
        prog.push_back(immWord(cpuPkg::OpAddi, 5'd2, 5'd0, b[15:0]));
        prog.push_back(rTypeWord(5'd3, 5'd1, 5'd2, cpuPkg::FnAdd));
        prog.push_back(rTypeWord(5'd4, 5'd1, 5'd2, cpuPkg::FnSub));
        prog.push_back(rTypeWord(5'd5, 5'd1, 5'd2, cpuPkg::FnAnd));
        prog.push_back(rTypeWord(5'd6, 5'd1, 5'd2, cpuPkg::FnOr));
        prog.push_back(rTypeWord(5'd7, 5'd1, 5'd2, cpuPkg::FnSlt));
        prog.push_back(rTypeWord(5'd8, 5'd2, 5'd1, cpuPkg::FnSlt));  // Reversed order
        for (i = 0; i < 6; i++) begin
            prog.push_back(immWord(cpuPkg::OpSw, cpuPkg::regAddr_t'(3 + i), 5'd0,
                                   16'(4 * i)));
        end
        prog.push_back({cpuPkg::OpHalt, 26'd0});
        loadProgram();
        runProgram(0);
        for (i = 0; i < 6; i++) begin
            peekWord(cpuPkg::word_t'(4 * i), got);
            checkWord($sformatf("dmem[0x%0h]", 4 * i), want[i], got);
        end
        checkCount("retired", cpuPkg::StepWidth'(prog.size() - 1), retired);  // All but HALT
    endtask

    task automatic loadStoreTest();
        logic [15:0]   imm1;
        logic [15:0]   imm2;
        cpuPkg::word_t v1;
        cpuPkg::word_t v2;
        cpuPkg::word_t got;
        imm1 = 16'($urandom);
        imm2 = 16'($urandom);
        v1   = {{16{imm1[15]}}, imm1};  // addi sign-extends
        v2   = {{16{imm2[15]}}, imm2};
        prog.delete();
        prog.push_back(immWord(cpuPkg::OpAddi, 5'd1, 5'd0, imm1));
        prog.push_back(immWord(cpuPkg::OpAddi, 5'd2, 5'd0, imm2));
        prog.push_back(immWord(cpuPkg::OpSw, 5'd1, 5'd0, 16'h0020));
        prog.push_back(immWord(cpuPkg::OpSw, 5'd2, 5'd0, 16'h0024));
        prog.push_back(immWord(cpuPkg::OpLw, 5'd3, 5'd0, 16'h0020));
        prog.push_back(immWord(cpuPkg::OpLw, 5'd4, 5'd0, 16'h0024));
        prog.push_back(rTypeWord(5'd5, 5'd3, 5'd4, cpuPkg::FnAdd));
        prog.push_back(immWord(cpuPkg::OpSw, 5'd5, 5'd0, 16'h0028));
        prog.push_back({cpuPkg::OpHalt, 26'd0});
        loadProgram();
        runProgram(0);
        peekWord(32'h20, got);
        checkWord("dmem[0x20]", v1, got);
        peekWord(32'h24, got);
        checkWord("dmem[0x24]", v2, got);
        peekWord(32'h28, got);
        checkWord("dmem[0x28]", v1 + v2, got);
    endtask

    task automatic branchTest();
        cpuPkg::word_t got;
        cpuPkg::word_t want [4];
        int            i;
        want[0] = 32'd1;  // beq not taken so marker stored
        want[1] = 32'd0;  // beq taken over marker
        want[2] = 32'd1;  // bne not taken
        want[3] = 32'd0;  // bne taken
        prog.delete();
        prog.push_back(immWord(cpuPkg::OpAddi, 5'd1, 5'd0, 16'd5));
        prog.push_back(immWord(cpuPkg::OpAddi, 5'd2, 5'd0, 16'd5));
        prog.push_back(immWord(cpuPkg::OpAddi, 5'd3, 5'd0, 16'd7));
        prog.push_back(immWord(cpuPkg::OpAddi, 5'd9, 5'd0, 16'd1));  // Marker value
        for (i = 0; i < 4; i++) begin
            prog.push_back(immWord(cpuPkg::OpSw, 5'd0, 5'd0, 16'(8'h80 + 4 * i)));
        end
        prog.push_back(immWord(cpuPkg::OpBeq, 5'd3, 5'd1, 16'd1));  // 5 != 7
        prog.push_back(immWord(cpuPkg::OpSw, 5'd9, 5'd0, 16'h0080));
        prog.push_back(immWord(cpuPkg::OpBeq, 5'd2, 5'd1, 16'd1));  // 5 == 5
        prog.push_back(immWord(cpuPkg::OpSw, 5'd9, 5'd0, 16'h0084));
        prog.push_back(immWord(cpuPkg::OpBne, 5'd2, 5'd1, 16'd1));
        prog.push_back(immWord(cpuPkg::OpSw, 5'd9, 5'd0, 16'h0088));
        prog.push_back(immWord(cpuPkg::OpBne, 5'd3, 5'd1, 16'd1));
        prog.push_back(immWord(cpuPkg::OpSw, 5'd9, 5'd0, 16'h008C));
        prog.push_back({cpuPkg::OpHalt, 26'd0});
        loadProgram();
        runProgram(0);
        for (i = 0; i < 4; i++) begin
            peekWord(cpuPkg::word_t'(8'h80 + 4 * i), got);
            checkWord($sformatf("marker[%0d]", i), want[i], got);
        end
        checkCount("retired", cpuPkg::StepWidth'(prog.size() - 1 - 2), retired);  // Two skipped
    endtask

    task automatic jumpTest();
        cpuPkg::word_t got;
        prog.delete();
        prog.push_back(immWord(cpuPkg::OpAddi, 5'd1, 5'd0, 16'h0055));
        prog.push_back(immWord(cpuPkg::OpAddi, 5'd2, 5'd0, 16'h00AA));
        prog.push_back(immWord(cpuPkg::OpSw, 5'd1, 5'd0, 16'h0040));  // Earlier value
        prog.push_back(jumpWord(26'd5));                               // To HALT at 0x14
        prog.push_back(immWord(cpuPkg::OpSw, 5'd2, 5'd0, 16'h0040));  // Skipped
        prog.push_back({cpuPkg::OpHalt, 26'd0});
        loadProgram();
        runProgram(0);
        peekWord(32'h40, got);
        checkWord("dmem[0x40]", 32'h0000_0055, got);
        checkCount("retired", cpuPkg::StepWidth'(4), retired);
    endtask

    task automatic budgetTest();
        prog.delete();
        prog.push_back(jumpWord(26'd0));  // Spins on itself
        loadProgram();
        runProgram(5);
        checkFlag("overrun", 1'b1, overrun);
        checkCount("retired", cpuPkg::StepWidth'(cpuPkg::MaxSteps), retired);
        prog.delete();
        prog.push_back(immWord(cpuPkg::OpAddi, 5'd1, 5'd0, 16'd1));
        prog.push_back({cpuPkg::OpHalt, 26'd0});
        loadProgram();
        runProgram(0);
        checkFlag("overrun", 1'b0, overrun);  // Cleared by new run
        checkCount("retired", cpuPkg::StepWidth'(1), retired);
    endtask

    initial begin
        void'($urandom(28972));
        reset    = 1'b1;
        runReq   = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        peekAddr = '0;
        repeat (10) @(posedge Clk);
        reset <= 1'b0;
        @(negedge Clk);
        checkFlag("runAck", 1'b0, runAck);  // Post-reset state
        checkFlag("overrun", 1'b0, overrun);
        checkCount("retired", '0, retired);
        aluTest();
        loadStoreTest();
        branchTest();
        jumpTest();
        budgetTest();
        finishRun();
    end

endmodule

//--- vlog.f
hw/cpuPkg.sv
hw/cpuCtrlIf.sv
hw/runControl.sv
hw/stepCounter.sv
hw/instrDecoder.sv
hw/fetchUnit.sv
hw/regFile.sv
hw/executeUnit.sv
hw/dataMem.sv
hw/cpuTop.sv
verif/cpuTb_asserts.sv
verif/cpuTb.sv

//--- Makefile
TOP = cpuTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f vlog.f -Mdir obj_dir -o simv

run: compile
	./obj_dir/simv | tee run.log
	grep -q "All tests passed!" run.log

clean:
	rm -rf obj_dir run.log
